// File: source/modexp_pkg.sv
`default_nettype none

package modexp_pkg;

	// ####################################################################
	// Widths
	// ####################################################################

	localparam int n_bits = 8;              // Operand width
	localparam int n_stages = n_bits;       // One pipeline stage per exponent bit
	localparam int prod_bits = 2 * n_bits;  // Full product before reduction

	// ####################################################################
	// Vector types
	// ####################################################################

	typedef logic [n_bits-1:0] word_t;      // Base, modulus, accumulator, result
	typedef logic [n_bits-1:0] exp_t;       // Left-aligned exponent
	typedef logic [prod_bits-1:0] prod_t;   // Double-width product
	typedef logic [n_bits:0] rem_t;         // Partial remainder with one guard bit

	localparam word_t word_one = word_t'(1);

	// ####################################################################
	// Pipeline item
	// ####################################################################

	// One operand set moving down the exponent pipeline
	typedef struct packed {
		logic  valid;     // Item present
		logic  started;   // First one bit of exponent already consumed
		word_t base;      // m
		exp_t  exponent;  // Remaining bits, next one at the top
		word_t modulus;   // n
		word_t acc;       // Partial result
	} stage_item_t;

endpackage

`default_nettype wire

// File: source/mod_mult.sv
`timescale 1ns/1ps
`default_nettype none

// Combinational (x * y) mod modulus
// The full product is reduced one bit at a time, MSB first, with a
// restoring compare-and-subtract after each shift.

module mod_mult (
	input  wire modexp_pkg::word_t x,
	input  wire modexp_pkg::word_t y,
	input  wire modexp_pkg::word_t modulus,
	output modexp_pkg::word_t product
);

	modexp_pkg::prod_t full_product;
	modexp_pkg::rem_t  mod_ext;
	modexp_pkg::rem_t  rem;
	logic              mod_zero;

	// ####################################################################
	// Product
	// ####################################################################

	assign full_product = x * y;            // Operands widen to prod_bits
	assign mod_ext = {1'b0, modulus};
	assign mod_zero = (modulus == '0);

	// ####################################################################
	// Reduction
	// ####################################################################

	// rem stays below modulus after every step, so rem * 2 + 1 never
	// needs more than n_bits + 1 bits
	always_comb
	begin
		rem = '0;
		for (int i = modexp_pkg::prod_bits - 1; i >= 0; i--)
		begin
			rem = {rem[modexp_pkg::n_bits-1:0], full_product[i]};
			if (rem >= mod_ext)
			begin
				rem = rem - mod_ext;           // Restore step
			end
		end
	end

	// Zero modulus has no meaningful remainder
	assign product = mod_zero ? '0 : rem[modexp_pkg::n_bits-1:0];

endmodule

`default_nettype wire

// File: source/exp_stage.sv
`timescale 1ns/1ps
`default_nettype none

// One left-to-right square-and-multiply step, registered.
// Consumes the top bit of the remaining exponent.

module exp_stage (
	input  wire clk,
	input  wire rst,
	input  wire modexp_pkg::stage_item_t item_in,
	output modexp_pkg::stage_item_t item_out
);

	logic              bit_top;
	modexp_pkg::word_t sq;
	modexp_pkg::word_t mul_x;
	modexp_pkg::word_t sq_mul;
	modexp_pkg::word_t acc_next;
	logic              started_next;

	logic              valid_q;
	logic              started_q;
	modexp_pkg::word_t base_q;
	modexp_pkg::exp_t  exp_q;
	modexp_pkg::word_t mod_q;
	modexp_pkg::word_t acc_q;

	assign bit_top = item_in.exponent[modexp_pkg::n_bits-1];

	// ####################################################################
	// Arithmetic
	// ####################################################################

	mod_mult u_square (
		.x       (item_in.acc),
		.y       (item_in.acc),
		.modulus (item_in.modulus),
		.product (sq)
	);

	// Before the first one bit the multiplier sees 1 * base,
	// which gives the base already reduced modulo n
	assign mul_x = item_in.started ? sq : modexp_pkg::word_one;

	mod_mult u_multiply (
		.x       (mul_x),
		.y       (item_in.base),
		.modulus (item_in.modulus),
		.product (sq_mul)
	);

	always_comb
	begin
		acc_next = item_in.acc;                // Leading zero bits leave acc alone
		started_next = item_in.started;
		if (item_in.started)
		begin
			acc_next = bit_top ? sq_mul : sq;
		end
		else if (bit_top)
		begin
			acc_next = sq_mul;                 // Load reduced base
			started_next = 1'b1;
		end
	end

	// ####################################################################
	// Stage register
	// ####################################################################

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= item_in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (item_in.valid)
		begin
			started_q <= started_next;
			base_q <= item_in.base;
			exp_q <= {item_in.exponent[modexp_pkg::n_bits-2:0], 1'b0};  // Next bit to top
			mod_q <= item_in.modulus;
			acc_q <= acc_next;
		end
	end

	always_comb
	begin
		item_out.valid = valid_q;
		item_out.started = started_q;
		item_out.base = base_q;
		item_out.exponent = exp_q;
		item_out.modulus = mod_q;
		item_out.acc = acc_q;
	end

endmodule

`default_nettype wire

// File: source/modexp_top.sv
`timescale 1ns/1ps
`default_nettype none

// Fully pipelined m^e mod n.
// Latency is n_stages + 1 cycles, one new operand set per cycle.

module modexp_top (
	input  wire clk,
	input  wire rst,
	input  wire in_valid,
	input  wire modexp_pkg::word_t base,
	input  wire modexp_pkg::exp_t exponent,
	input  wire modexp_pkg::word_t modulus,
	output logic out_valid,
	output modexp_pkg::word_t result
);

	logic              cap_valid;
	modexp_pkg::word_t cap_base;
	modexp_pkg::exp_t  cap_exp;
	modexp_pkg::word_t cap_mod;

	modexp_pkg::stage_item_t chain [0:modexp_pkg::n_stages];
	modexp_pkg::stage_item_t last_item;
	modexp_pkg::word_t       one_mod_n;

	// ####################################################################
	// Operand capture
	// ####################################################################

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cap_valid <= 1'b0;
		else
			cap_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			cap_base <= base;
			cap_exp <= exponent;
			cap_mod <= modulus;
		end
	end

	// Fresh item has seen no exponent bit yet
	always_comb
	begin
		chain[0].valid = cap_valid;
		chain[0].started = 1'b0;
		chain[0].base = cap_base;
		chain[0].exponent = cap_exp;
		chain[0].modulus = cap_mod;
		chain[0].acc = '0;
	end

	// ####################################################################
	// Exponent pipeline
	// ####################################################################

	for (genvar k = 0; k < modexp_pkg::n_stages; k++)
	begin : g_stage
		exp_stage u_stage (
			.clk      (clk),
			.rst      (rst),
			.item_in  (chain[k]),
			.item_out (chain[k+1])
		);
	end

	assign last_item = chain[modexp_pkg::n_stages];

	// ####################################################################
	// Result rule
	// ####################################################################

	// Zero exponent ends with 1 mod n, which is 0 for n == 1
	mod_mult u_one_mod (
		.x       (modexp_pkg::word_one),
		.y       (modexp_pkg::word_one),
		.modulus (last_item.modulus),
		.product (one_mod_n)
	);

	always_comb
	begin
		if (last_item.modulus == '0)
			result = '0;
		else if (!last_item.started)
			result = one_mod_n;
		else
			result = last_item.acc;
	end

	assign out_valid = last_item.valid;

endmodule

`default_nettype wire

// File: test/modexp_model.svh
`ifndef MODEXP_MODEL_SVH
`define MODEXP_MODEL_SVH

// ####################################################################
// Reference arithmetic for the testbench
// ####################################################################

// (x * y) mod n, zero for a zero modulus
function automatic modexp_pkg::word_t model_mod_mult(
	input modexp_pkg::word_t x,
	input modexp_pkg::word_t y,
	input modexp_pkg::word_t n
);
	modexp_pkg::prod_t p;
	modexp_pkg::prod_t n_ext;
	if (n == '0)
		return '0;
	p = x * y;
	n_ext = modexp_pkg::prod_t'(n);
	return modexp_pkg::word_t'(p % n_ext);
endfunction

// m^e mod n, left-to-right square-and-multiply
function automatic modexp_pkg::word_t model_mod_exp(
	input modexp_pkg::word_t m,
	input modexp_pkg::exp_t  e,
	input modexp_pkg::word_t n
);
	modexp_pkg::word_t acc;
	if (n == '0)
		return '0;
	acc = model_mod_mult(modexp_pkg::word_one, modexp_pkg::word_one, n);  // 1 mod n
	for (int i = modexp_pkg::n_bits - 1; i >= 0; i--)
	begin
		acc = model_mod_mult(acc, acc, n);
		if (e[i])
			acc = model_mod_mult(acc, m, n);
	end
	return acc;
endfunction

`endif

// File: test/tb_modexp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_modexp;

	`include "modexp_model.svh"

	localparam int latency = modexp_pkg::n_stages + 1;  // Capture edge plus one edge per stage
	localparam int reset_cycles = 3;
	localparam int n_idle = 5;
	localparam int n_random = 300;
	localparam int n_edge = 12;
	localparam int n_gap = 200;
	localparam int n_pre_reset = 20;
	localparam int n_fresh = 50;
	localparam int cycle_limit = 2 * reset_cycles + n_idle + n_random + n_edge + n_gap
		+ n_pre_reset + n_fresh + 3 * (latency + 2) + 20;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    in_valid;
	modexp_pkg::word_t       base;
	modexp_pkg::exp_t        exponent;
	modexp_pkg::word_t       modulus;
	logic                    out_valid;
	modexp_pkg::word_t       result;

	logic                    hand_valid;   // Expected value given directly by the stimulus
	modexp_pkg::word_t       hand_value;
	logic [31:0]             rng_state = 32'd38240;
	int                      cycle = 0;
	modexp_pkg::word_t       expected_q [$];
	int                      issue_q [$];

	modexp_top modexp_top_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.base      (base),
		.exponent  (exponent),
		.modulus   (modulus),
		.out_valid (out_valid),
		.result    (result)
	);

	always #50 clk = ~clk;

	// ####################################################################
	// Helpers
	// ####################################################################

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic random_byte(output modexp_pkg::word_t v);
		rng_state = lcg_step(rng_state);
		v = rng_state[23:16];                  // Low LCG bits repeat too soon
	endtask

	task automatic drive_item(
		input modexp_pkg::word_t m,
		input modexp_pkg::exp_t  e,
		input modexp_pkg::word_t n,
		input logic              hand,
		input modexp_pkg::word_t hand_val
	);
		@(posedge clk);
		in_valid <= 1'b1;
		base <= m;
		exponent <= e;
		modulus <= n;
		hand_valid <= hand;
		hand_value <= hand_val;
	endtask

	task automatic drive_idle;
		@(posedge clk);
		in_valid <= 1'b0;
		hand_valid <= 1'b0;
	endtask

	task automatic random_item;
		modexp_pkg::word_t m;
		modexp_pkg::exp_t  e;
		modexp_pkg::word_t n;
		random_byte(m);
		random_byte(e);
		random_byte(n);
		drive_item(m, e, n, 1'b0, 8'd0);
	endtask

	task automatic drain_pipeline;
		drive_idle();
		while (expected_q.size() != 0)
			@(posedge clk);
	endtask

	// ####################################################################
	// Output checking
	// ####################################################################

	task automatic check_output;
		modexp_pkg::word_t want;
		int                issued;
		assert (expected_q.size() != 0)
			else fail_run("out_valid went high with no item in flight");
		want = expected_q.pop_front();
		issued = issue_q.pop_front();
		assert (cycle - issued == latency)
			else fail_run($sformatf("MISMATCH at %0t: out_valid latency expected %0d got %0d",
				$time, latency, cycle - issued));
		assert (result == want)
			else fail_run($sformatf("MISMATCH at %0t: result expected 0x%02h got 0x%02h",
				$time, want, result));
	endtask

	// DUT outputs and driven inputs are settled on the falling edge
	always @(negedge clk)
	begin
		if (rst)
		begin
			assert (!out_valid)
				else fail_run("out_valid high while rst is asserted");
			expected_q.delete();                 // In-flight items are lost
			issue_q.delete();
		end
		else
		begin
			if (out_valid)
				check_output();
			if (in_valid)
			begin
				expected_q.push_back(hand_valid ? hand_value
					: model_mod_exp(base, exponent, modulus));
				issue_q.push_back(cycle);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > cycle_limit)
			fail_run("Timeout: the run did not finish within its cycle limit");
	end

	// ####################################################################
	// Stimulus
	// ####################################################################

	initial
	begin
		rst <= 1'b1;
		in_valid <= 1'b0;
		base <= '0;
		exponent <= '0;
		modulus <= '0;
		hand_valid <= 1'b0;
		hand_value <= '0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;

		repeat (n_idle) drive_idle();          // Nothing may come out yet

		repeat (n_random) random_item();

		// Edge operands with hand-worked results
		drive_item(8'd5, 8'd0, 8'd7, 1'b1, 8'd1);
		drive_item(8'd5, 8'd0, 8'd1, 1'b1, 8'd0);
		drive_item(8'd9, 8'd13, 8'd0, 1'b1, 8'd0);
		drive_item(8'd250, 8'd0, 8'd0, 1'b1, 8'd0);
		drive_item(8'd0, 8'd5, 8'd11, 1'b1, 8'd0);
		drive_item(8'd0, 8'd0, 8'd11, 1'b1, 8'd1);
		drive_item(8'd200, 8'd3, 8'd13, 1'b1, 8'd8);
		drive_item(8'd255, 8'd255, 8'd255, 1'b1, 8'd0);
		drive_item(8'd7, 8'd1, 8'd3, 1'b1, 8'd1);
		drive_item(8'd2, 8'd8, 8'd251, 1'b1, 8'd5);
		drive_item(8'd3, 8'd255, 8'd1, 1'b1, 8'd0);
		drive_item(8'd255, 8'd2, 8'd254, 1'b1, 8'd1);
		drain_pipeline();

		// Random gaps in in_valid
		for (int i = 0; i < n_gap; i++)
		begin
			modexp_pkg::word_t g;
			random_byte(g);
			if (g < 8'd150)
				random_item();
			else
				drive_idle();
		end
		drain_pipeline();

		// Reset in the middle of a stream
		repeat (n_pre_reset) random_item();
		@(posedge clk);
		rst <= 1'b1;
		in_valid <= 1'b0;
		hand_valid <= 1'b0;
		repeat (reset_cycles - 1) @(posedge clk);
		@(posedge clk);
		rst <= 1'b0;

		repeat (n_fresh) random_item();
		drive_idle();
		repeat (latency) @(posedge clk);       // Last item leaves before this edge

		if (expected_q.size() != 0)
			fail_run("Results still missing after the final drain");
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+test
source/modexp_pkg.sv
source/mod_mult.sv
source/exp_stage.sv
source/modexp_top.sv
test/tb_modexp.sv

// File: run.sh
#!/bin/sh
# Build and run the modexp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f tb.f \
	--top-module tb_modexp \
	--Mdir obj_dir \
	-o tb_modexp_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_modexp_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^All tests passed$"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
